// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;
    localparam int XLEN        = 32;
    localparam int N_ARF_REGS  = 32;
    localparam int ROB_DEPTH   = 8;
    localparam int IQ_DEPTH    = 4;
    localparam int N_ALU_LANES = 2;

    // major opcodes of the supported integer formats
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef logic [XLEN-1:0]               reg_data_t;
    typedef logic [XLEN-1:0]               addr_t;
    typedef logic [31:0]                   instr_t;
    typedef logic [XLEN-1:0]               imm_t;
    typedef logic [$clog2(N_ARF_REGS)-1:0] arf_id_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]  rob_id_t;
    typedef logic [2:0]                    funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_t;

    typedef enum logic [1:0] {
        ROB_FREE,
        ROB_WAITING,
        ROB_DONE
    } rob_state_t;

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
    } ififo_entry_t;

    typedef struct packed {
        alu_op_t   op;
        logic      src1_ready;
        rob_id_t   src1_rob_id;  // tag while not ready
        reg_data_t src1_data;
        logic      src2_ready;
        rob_id_t   src2_rob_id;
        reg_data_t src2_data;
        imm_t      imm;
        logic      use_imm;
        addr_t     pc;
        rob_id_t   dst_rob_id;
    } iiq_entry_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t reg_data;
    } broadcast_t;

    typedef struct packed {
        logic    dst_valid;
        arf_id_t dst_arf_id;
        addr_t   pc;
    } rob_dispatch_t;

    typedef struct packed {
        addr_t     pc;
        logic      dst_valid;
        arf_id_t   arf_id;
        reg_data_t reg_data;
    } retire_t;
endpackage

`default_nettype wire

// ==== verilog/decode.sv ====
`default_nettype none
`timescale 1ns/100ps

module decode import core_pkg::*; (
    input  wire instr_t instr,
    output alu_op_t     op,
    output arf_id_t     rs1,
    output arf_id_t     rs2,
    output arf_id_t     rd,
    output logic        rs1_valid,
    output logic        rs2_valid,
    output logic        rd_valid,
    output imm_t        imm,
    output logic        use_imm
);
    funct3_t funct3;
    logic    known;  // one of the supported opcodes

    function automatic alu_op_t alu_fn(funct3_t f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    always_comb begin
        op        = ALU_ADD;
        known     = 1'b1;
        rs1_valid = 1'b0;
        rs2_valid = 1'b0;
        use_imm   = 1'b1;
        imm       = {{20{instr[31]}}, instr[31:20]};  // I-type
        case (instr[6:0])
            OPC_OP: begin
                op        = alu_fn(funct3, instr[30]);
                rs1_valid = 1'b1;
                rs2_valid = 1'b1;
                use_imm   = 1'b0;
            end
            OPC_OP_IMM: begin
                // bit 30 only selects srai, addi has no subtract form
                op        = alu_fn(funct3, instr[30] && funct3 == 3'b101);
                rs1_valid = 1'b1;
            end
            OPC_LUI: begin
                op  = ALU_LUI;
                imm = {instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                op  = ALU_AUIPC;
                imm = {instr[31:12], 12'b0};
            end
            default: known = 1'b0;
        endcase
        rd_valid = known && (rd != '0);  // x0 writes are dropped here
    end
endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

module regfile #(
    parameter int ENTRY_WIDTH   = 32,
    parameter int N_ENTRIES     = 32,
    parameter int N_READ_PORTS  = 2,
    parameter int N_WRITE_PORTS = 1
) (
    input  wire                                                 clk,
    input  wire                                                 arst_n,
    input  wire  [N_READ_PORTS-1:0][$clog2(N_ENTRIES)-1:0]      rd_addr,
    output logic [N_READ_PORTS-1:0][ENTRY_WIDTH-1:0]            rd_data,
    input  wire  [N_WRITE_PORTS-1:0]                            wr_en,
    input  wire  [N_WRITE_PORTS-1:0][$clog2(N_ENTRIES)-1:0]     wr_addr,
    input  wire  [N_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0]           wr_data
);
    logic [ENTRY_WIDTH-1:0] mem_q [N_ENTRIES];

    for (genvar r = 0; r < N_READ_PORTS; r++) begin : g_rd
        assign rd_data[r] = mem_q[rd_addr[r]];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_ENTRIES; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            for (int w = 0; w < N_WRITE_PORTS; w++) begin
                if (wr_en[w]) begin
                    mem_q[wr_addr[w]] <= wr_data[w];  // later port overrides
                end
            end
        end
    end
endmodule

`default_nettype wire

// ==== verilog/dispatch.sv ====
`default_nettype none
`timescale 1ns/100ps

module dispatch import core_pkg::*; (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               ififo_valid,
    output logic                              ififo_ready,
    input  wire ififo_entry_t                 ififo_data,
    input  wire                               rob_alloc_ready,
    output logic                              rob_alloc_valid,
    output rob_dispatch_t                     rob_alloc_data,
    input  wire rob_id_t                      rob_alloc_id,
    output rob_id_t [1:0]                     rob_src_id,
    input  wire [1:0]                         rob_src_ready,
    input  wire reg_data_t [1:0]              rob_src_data,
    output arf_id_t [1:0]                     arf_src_addr,
    input  wire reg_data_t [1:0]              arf_src_data,
    input  wire                               iq_ready,
    output logic                              iq_valid,
    output iiq_entry_t                        iq_data,
    input  wire broadcast_t [N_ALU_LANES-1:0] bcast,
    input  wire                               retire_valid,
    input  wire retire_t                      retire_data
);
    alu_op_t               op;
    arf_id_t               rs1;
    arf_id_t               rs2;
    arf_id_t               rd;
    logic                  rs1_valid;
    logic                  rs2_valid;
    logic                  rd_valid;
    imm_t                  imm;
    logic                  use_imm;
    logic                  transfer;
    logic                  rename_rd;
    logic                  live_q;     // first cycle out of reset has passed
    logic [N_ARF_REGS-1:0] renamed_q;  // retired-bit table, 1 = newest value lives in the ROB
    rob_id_t               ret_ptr_q;  // tracks the ROB head since retire is in order
    rob_id_t [2:0]         tag_rd;
    logic [1:0]            src_used;
    logic [1:0]            src_ready;
    reg_data_t [1:0]       src_data;

    decode u_decode (
        .instr(ififo_data.instr),
        .op(op),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .rs1_valid(rs1_valid),
        .rs2_valid(rs2_valid),
        .rd_valid(rd_valid),
        .imm(imm),
        .use_imm(use_imm)
    );

    assign ififo_ready = live_q && rob_alloc_ready && iq_ready;
    assign transfer    = ififo_valid && ififo_ready;
    assign rename_rd   = transfer && rd_valid;

    // tag table, ports 0/1 for the sources and 2 for the retiring register
    regfile #(
        .ENTRY_WIDTH($bits(rob_id_t)),
        .N_ENTRIES(N_ARF_REGS),
        .N_READ_PORTS(3),
        .N_WRITE_PORTS(1)
    ) u_tag_table (
        .clk(clk),
        .arst_n(arst_n),
        .rd_addr({retire_data.arf_id, rs2, rs1}),
        .rd_data(tag_rd),
        .wr_en(rename_rd),
        .wr_addr(rd),
        .wr_data(rob_alloc_id)
    );

    assign arf_src_addr = {rs2, rs1};
    assign rob_src_id   = tag_rd[1:0];
    assign src_used     = {rs2_valid, rs1_valid};

    // operand select: x0 or unused, ARF if retired, then same-cycle broadcast, then ROB
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_ready[s] = rob_src_ready[s];
            src_data[s]  = rob_src_data[s];
            if (!src_used[s] || arf_src_addr[s] == '0) begin
                src_ready[s] = 1'b1;
                src_data[s]  = '0;
            end else if (!renamed_q[arf_src_addr[s]]) begin
                src_ready[s] = 1'b1;
                src_data[s]  = arf_src_data[s];
            end else begin
                for (int l = 0; l < N_ALU_LANES; l++) begin
                    if (bcast[l].valid && bcast[l].rob_id == tag_rd[s]) begin
                        src_ready[s] = 1'b1;
                        src_data[s]  = bcast[l].reg_data;
                    end
                end
            end
        end
    end

    assign rob_alloc_valid = transfer;
    assign rob_alloc_data  = '{dst_valid: rd_valid, dst_arf_id: rd, pc: ififo_data.pc};

    assign iq_valid = transfer;
    assign iq_data  = '{
        op: op,
        src1_ready: src_ready[0], src1_rob_id: tag_rd[0], src1_data: src_data[0],
        src2_ready: src_ready[1], src2_rob_id: tag_rd[1], src2_data: src_data[1],
        imm: imm,
        use_imm: use_imm,
        pc: ififo_data.pc,
        dst_rob_id: rob_alloc_id
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live_q    <= 1'b0;
            ret_ptr_q <= '0;
            renamed_q <= '0;
        end else begin
            live_q <= 1'b1;
            if (retire_valid) begin
                ret_ptr_q <= ret_ptr_q + 1'b1;
                // only if no younger writer renamed the register meanwhile
                if (retire_data.dst_valid && tag_rd[2] == ret_ptr_q) begin
                    renamed_q[retire_data.arf_id] <= 1'b0;
                end
            end
            if (rename_rd) begin
                renamed_q[rd] <= 1'b1;  // beats a same-cycle clear
            end
        end
    end
endmodule

`default_nettype wire

// ==== verilog/issue_queue.sv ====
`default_nettype none
`timescale 1ns/100ps

module issue_queue import core_pkg::*; (
    input  wire                               clk,
    input  wire                               arst_n,
    output logic                              enq_ready,
    input  wire                               enq_valid,
    input  wire iiq_entry_t                   enq_data,
    input  wire broadcast_t [N_ALU_LANES-1:0] bcast,
    output logic [N_ALU_LANES-1:0]            iss_valid,
    output iiq_entry_t [N_ALU_LANES-1:0]      iss_data
);
    iiq_entry_t          q_data [IQ_DEPTH];  // index 0 is the oldest
    logic [IQ_DEPTH-1:0] q_valid;
    iiq_entry_t          nxt_data [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] nxt_valid;
    logic [IQ_DEPTH-1:0] issued;

    // capture broadcast results into waiting sources
    function automatic iiq_entry_t wake(iiq_entry_t e, broadcast_t [N_ALU_LANES-1:0] b);
        iiq_entry_t r;
        r = e;
        for (int l = 0; l < N_ALU_LANES; l++) begin
            if (b[l].valid && !r.src1_ready && b[l].rob_id == r.src1_rob_id) begin
                r.src1_ready = 1'b1;
                r.src1_data  = b[l].reg_data;
            end
            if (b[l].valid && !r.src2_ready && b[l].rob_id == r.src2_rob_id) begin
                r.src2_ready = 1'b1;
                r.src2_data  = b[l].reg_data;
            end
        end
        return r;
    endfunction

    assign enq_ready = !q_valid[IQ_DEPTH-1];  // compacted, so full when the last slot is used

    // oldest-first select into the lanes
    always_comb begin
        int lane;
        lane      = 0;
        issued    = '0;
        iss_valid = '0;
        iss_data  = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (q_valid[i] && q_data[i].src1_ready && q_data[i].src2_ready
                    && lane < N_ALU_LANES) begin
                issued[i]       = 1'b1;
                iss_valid[lane] = 1'b1;
                iss_data[lane]  = q_data[i];
                lane++;
            end
        end
    end

    // drop issued entries, shift the rest down, append the new one
    always_comb begin
        int n;
        n         = 0;
        nxt_data  = q_data;
        nxt_valid = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (q_valid[i] && !issued[i]) begin
                nxt_data[n]  = wake(q_data[i], bcast);
                nxt_valid[n] = 1'b1;
                n++;
            end
        end
        if (enq_valid && enq_ready && n < IQ_DEPTH) begin
            nxt_data[n]  = enq_data;
            nxt_valid[n] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_valid <= '0;
        end else begin
            q_valid <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        q_data <= nxt_data;
    end
endmodule

`default_nettype wire

// ==== verilog/alu_lane.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu_lane import core_pkg::*; (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             iss_valid,
    input  wire iiq_entry_t iss_data,
    output broadcast_t      bcast
);
    reg_data_t opa;
    reg_data_t opb;
    reg_data_t result;
    logic      valid_q;
    rob_id_t   rob_id_q;
    reg_data_t data_q;

    assign opa = iss_data.src1_data;
    assign opb = iss_data.use_imm ? iss_data.imm : iss_data.src2_data;

    always_comb begin
        case (iss_data.op)
            ALU_ADD:   result = opa + opb;
            ALU_SUB:   result = opa - opb;
            ALU_SLL:   result = opa << opb[4:0];
            ALU_SLT:   result = {31'b0, $signed(opa) < $signed(opb)};
            ALU_SLTU:  result = {31'b0, opa < opb};
            ALU_XOR:   result = opa ^ opb;
            ALU_SRL:   result = opa >> opb[4:0];
            ALU_SRA:   result = $signed(opa) >>> opb[4:0];
            ALU_OR:    result = opa | opb;
            ALU_AND:   result = opa & opb;
            ALU_LUI:   result = opb;  // immediate already shifted
            ALU_AUIPC: result = iss_data.pc + opb;
            default:   result = opa + opb;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            rob_id_q <= iss_data.dst_rob_id;
            data_q   <= result;
        end
    end

    assign bcast = '{valid: valid_q, rob_id: rob_id_q, reg_data: data_q};
endmodule

`default_nettype wire

// ==== verilog/rob.sv ====
`default_nettype none
`timescale 1ns/100ps

module rob import core_pkg::*; (
    input  wire                               clk,
    input  wire                               arst_n,
    output logic                              alloc_ready,
    input  wire                               alloc_valid,
    input  wire rob_dispatch_t                alloc_data,
    output rob_id_t                           alloc_id,
    input  wire broadcast_t [N_ALU_LANES-1:0] wb,
    input  wire rob_id_t [1:0]                src_id,
    output logic [1:0]                        src_ready,
    output reg_data_t [1:0]                   src_data,
    output logic                              retire_valid,
    output retire_t                           retire_data
);
    rob_state_t    state_q [ROB_DEPTH];
    rob_dispatch_t meta_q [ROB_DEPTH];
    reg_data_t     data_q [ROB_DEPTH];
    rob_id_t       head_q;
    rob_id_t       tail_q;  // pointers wrap on their own, depth is a power of two

    assign alloc_ready  = state_q[tail_q] == ROB_FREE;
    assign alloc_id     = tail_q;
    assign retire_valid = state_q[head_q] == ROB_DONE;
    assign retire_data  = '{
        pc: meta_q[head_q].pc,
        dst_valid: meta_q[head_q].dst_valid,
        arf_id: meta_q[head_q].dst_arf_id,
        reg_data: data_q[head_q]
    };

    for (genvar s = 0; s < 2; s++) begin : g_src
        assign src_ready[s] = state_q[src_id[s]] == ROB_DONE;
        assign src_data[s]  = data_q[src_id[s]];
    end

    // alloc hits a free slot and retire a done one, never the same slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= ROB_FREE;
            end
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (alloc_valid) begin
                state_q[tail_q] <= ROB_WAITING;
                tail_q          <= tail_q + 1'b1;
            end
            for (int l = 0; l < N_ALU_LANES; l++) begin
                if (wb[l].valid) begin
                    state_q[wb[l].rob_id] <= ROB_DONE;
                end
            end
            if (retire_valid) begin
                state_q[head_q] <= ROB_FREE;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            meta_q[tail_q] <= alloc_data;
        end
        for (int l = 0; l < N_ALU_LANES; l++) begin
            if (wb[l].valid) begin
                data_q[wb[l].rob_id] <= wb[l].reg_data;
            end
        end
    end
endmodule

`default_nettype wire

// ==== verilog/rename_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module rename_core import core_pkg::*; (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               ififo_valid,
    output logic              ififo_ready,
    input  wire ififo_entry_t ififo_data,
    output logic              retire_valid,
    output retire_t           retire_data
);
    logic                          rob_alloc_ready;
    logic                          rob_alloc_valid;
    rob_dispatch_t                 rob_alloc_data;
    rob_id_t                       rob_alloc_id;
    rob_id_t [1:0]                 rob_src_id;
    logic [1:0]                    rob_src_ready;
    reg_data_t [1:0]               rob_src_data;
    arf_id_t [1:0]                 arf_src_addr;
    reg_data_t [1:0]               arf_src_data;
    logic                          iq_ready;
    logic                          iq_valid;
    iiq_entry_t                    iq_data;
    logic [N_ALU_LANES-1:0]        iss_valid;
    iiq_entry_t [N_ALU_LANES-1:0]  iss_data;
    broadcast_t [N_ALU_LANES-1:0]  bcast;  // lane results, one per lane

    dispatch u_dispatch (
        .clk(clk), .arst_n(arst_n),
        .ififo_valid(ififo_valid), .ififo_ready(ififo_ready), .ififo_data(ififo_data),
        .rob_alloc_ready(rob_alloc_ready), .rob_alloc_valid(rob_alloc_valid),
        .rob_alloc_data(rob_alloc_data), .rob_alloc_id(rob_alloc_id),
        .rob_src_id(rob_src_id), .rob_src_ready(rob_src_ready), .rob_src_data(rob_src_data),
        .arf_src_addr(arf_src_addr), .arf_src_data(arf_src_data),
        .iq_ready(iq_ready), .iq_valid(iq_valid), .iq_data(iq_data),
        .bcast(bcast),
        .retire_valid(retire_valid), .retire_data(retire_data)
    );

    rob u_rob (
        .clk(clk), .arst_n(arst_n),
        .alloc_ready(rob_alloc_ready), .alloc_valid(rob_alloc_valid),
        .alloc_data(rob_alloc_data), .alloc_id(rob_alloc_id),
        .wb(bcast),
        .src_id(rob_src_id), .src_ready(rob_src_ready), .src_data(rob_src_data),
        .retire_valid(retire_valid), .retire_data(retire_data)
    );

    // architectural state, written only at retire
    regfile #(
        .ENTRY_WIDTH($bits(reg_data_t)),
        .N_ENTRIES(N_ARF_REGS),
        .N_READ_PORTS(2),
        .N_WRITE_PORTS(1)
    ) u_arf (
        .clk(clk),
        .arst_n(arst_n),
        .rd_addr(arf_src_addr),
        .rd_data(arf_src_data),
        .wr_en(retire_valid && retire_data.dst_valid),
        .wr_addr(retire_data.arf_id),
        .wr_data(retire_data.reg_data)
    );

    issue_queue u_issue_queue (
        .clk(clk), .arst_n(arst_n),
        .enq_ready(iq_ready), .enq_valid(iq_valid), .enq_data(iq_data),
        .bcast(bcast),
        .iss_valid(iss_valid), .iss_data(iss_data)
    );

    for (genvar l = 0; l < N_ALU_LANES; l++) begin : g_lane
        alu_lane u_alu_lane (
            .clk(clk),
            .arst_n(arst_n),
            .iss_valid(iss_valid[l]),
            .iss_data(iss_data[l]),
            .bcast(bcast[l])
        );
    end
endmodule

`default_nettype wire

// ==== test/rename_core_assertions.sv ====
`default_nettype none
`timescale 1ns/100ps

module rename_core_assertions import core_pkg::*; (
    input wire                               clk,
    input wire                               arst_n,
    input wire                               ififo_valid,
    input wire                               ififo_ready,
    input wire ififo_entry_t                 ififo_data,
    input wire                               retire_valid,
    input wire broadcast_t [N_ALU_LANES-1:0] bcast
);
    // a stalled instruction must stay on the bus unchanged
    a_hold_until_ready: assert property (@(posedge clk) disable iff (!arst_n)
        ififo_valid && !ififo_ready |=> ififo_valid && $stable(ififo_data))
        else $error("instruction input changed before it was accepted");

    a_no_retire_in_reset: assert property (@(posedge clk)
        !arst_n |-> !retire_valid)
        else $error("retire_valid high during reset");

    for (genvar i = 0; i < N_ALU_LANES; i++) begin : g_lane_a
        for (genvar j = i + 1; j < N_ALU_LANES; j++) begin : g_lane_b
            a_unique_bcast: assert property (@(posedge clk) disable iff (!arst_n)
                bcast[i].valid && bcast[j].valid |-> bcast[i].rob_id != bcast[j].rob_id)
                else $error("two lanes broadcast the same rob_id");
        end
    end
endmodule

bind rename_core rename_core_assertions u_assertions (
    .clk(clk),
    .arst_n(arst_n),
    .ififo_valid(ififo_valid),
    .ififo_ready(ififo_ready),
    .ififo_data(ififo_data),
    .retire_valid(retire_valid),
    .bcast(bcast)
);

`default_nettype wire

// ==== test/tb_rename_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_rename_core import core_pkg::*; ();
    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] SEED         = 32'h96cb6f54;

    logic         clk;
    logic         arst_n;
    logic         ififo_valid;
    logic         ififo_ready;
    ififo_entry_t ififo_data;
    logic         retire_valid;
    retire_t      retire_data;

    logic [31:0]  rng_state;
    reg_data_t    model_regs [N_ARF_REGS];  // architectural state of the reference
    ififo_entry_t stim_q [$];
    int           gap_q [$];  // idle cycles after each instruction
    retire_t      expect_q [$];
    string        name_q [$];
    addr_t        next_pc;
    int           total       = 0;
    int           sent        = 0;
    int           retired     = 0;
    int           cycle_count = 0;
    int           cycle_limit = 0;

    rename_core u_dut (
        .clk(clk),
        .arst_n(arst_n),
        .ififo_valid(ififo_valid),
        .ififo_ready(ififo_ready),
        .ififo_data(ififo_data),
        .retire_valid(retire_valid),
        .retire_data(retire_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // executes one instruction on the register model, in program order
    function automatic retire_t model_exec(instr_t instr, addr_t pc);
        retire_t   r;
        reg_data_t a;
        reg_data_t b;
        reg_data_t res;
        reg_data_t sra_res;
        logic      alt;
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        alt = instr[30];
        if (instr[6:0] == 7'b0010011) begin
            b   = {{20{instr[31]}}, instr[31:20]};
            alt = instr[30] && instr[14:12] == 3'b101;  // only srai has an alternate form
        end
        sra_res = $signed(a) >>> b[4:0];
        case (instr[14:12])
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? sra_res : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (instr[6:0] == 7'b0110111) res = {instr[31:12], 12'b0};       // lui
        if (instr[6:0] == 7'b0010111) res = pc + {instr[31:12], 12'b0};  // auipc
        r.pc        = pc;
        r.dst_valid = instr[11:7] != 5'd0;
        r.arf_id    = instr[11:7];
        r.reg_data  = res;
        if (r.dst_valid) model_regs[instr[11:7]] = res;
        return r;
    endfunction

    // kind 0 add 1 sub 2 sll 3 slt 4 sltu 5 xor 6 srl 7 sra 8 or 9 and 10 lui 11 auipc
    function automatic instr_t build_instr(int kind, logic use_imm, arf_id_t rd,
                                           arf_id_t rs1, arf_id_t rs2);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [31:0] r;
        r   = next_rand();
        alt = kind == 1 || kind == 7;
        case (kind)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b001;
            3:       f3 = 3'b010;
            4:       f3 = 3'b011;
            5:       f3 = 3'b100;
            6, 7:    f3 = 3'b101;
            8:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        if (kind == 10) return {r[31:12], rd, 7'b0110111};
        if (kind == 11) return {r[31:12], rd, 7'b0010111};
        if (use_imm && kind != 1) begin  // no subi so sub stays register form
            imm12 = r[11:0];
            if (f3 == 3'b001 || f3 == 3'b101) imm12 = {1'b0, alt, 5'b0, r[4:0]};
            return {imm12, rs1, f3, rd, 7'b0010011};
        end
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    task automatic queue_instr(string test, instr_t instr, addr_t pc, int gap);
        ififo_entry_t e;
        e.instr = instr;
        e.pc    = pc;
        stim_q.push_back(e);
        gap_q.push_back(gap);
        expect_q.push_back(model_exec(instr, pc));
        name_q.push_back(test);
    endtask

    task automatic push_seq(string test, instr_t instr, int gap);
        queue_instr(test, instr, next_pc, gap);
        next_pc += 4;
    endtask

    task automatic build_program();
        logic [31:0] r;
        arf_id_t     rd;
        arf_id_t     prev_rd;
        next_pc = 32'h0000_1000;
        for (int i = 1; i < N_ARF_REGS; i++) begin
            push_seq("init", build_instr(10, 1'b0, 5'(i), 5'd0, 5'd0), 0);
            push_seq("init", build_instr(0, 1'b1, 5'(i), 5'(i), 5'd0), 0);
        end
        // writes x16..x31 and reads x1..x15 only
        for (int i = 0; i < 48; i++) begin
            r = next_rand();
            push_seq("independent", build_instr(i % 12, 1'((i / 12) % 2), 5'(16 + i % 16),
                     5'(1 + r[7:0] % 15), 5'(1 + r[15:8] % 15)), 0);
        end
        prev_rd = 5'd5;
        for (int i = 0; i < 40; i++) begin
            r  = next_rand();
            rd = r[23] ? prev_rd : 5'(1 + r[15:8] % 31);  // sometimes renames the same reg
            push_seq("chain", build_instr(int'(r % 12), r[16], rd, prev_rd,
                     r[17] ? prev_rd : r[22:18]), 0);
            prev_rd = rd;
        end
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            if (i % 2 == 0) begin
                push_seq("x0", build_instr(int'(r % 12), r[16], 5'd0, r[21:17], r[26:22]), 0);
            end else begin
                push_seq("x0", build_instr(int'(r % 10), r[16], 5'(1 + r[15:8] % 31), 5'd0,
                         r[1] ? 5'd0 : r[26:22]), 0);
            end
        end
        // few registers keep the queue and the ROB busy
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            push_seq("backpressure", build_instr(int'(r % 12), r[6], 5'(1 + r[9:8]),
                     5'(1 + r[11:10]), 5'(1 + r[13:12])), (r[21:20] == 2'd0) ? 1 + r[22] : 0);
        end
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            queue_instr("upper_imm", build_instr(10 + i % 2, 1'b0, r[4:0], 5'd0, 5'd0),
                        {r[31:2], 2'b00}, 0);
        end
    endtask

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string test, string field, logic [31:0] expected,
                               logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH test %s %s expected %h actual %h",
                                test, field, expected, actual));
        end
    endtask

    task automatic send_all();
        for (int i = 0; i < stim_q.size(); i++) begin
            ififo_valid = 1'b1;
            ififo_data  = stim_q[i];
            @(negedge clk);
            while (!ififo_ready) @(negedge clk);
            @(posedge clk);  // accepted at this edge
            #DRIVE_DELAY;
            if (gap_q[i] > 0) begin
                ififo_valid = 1'b0;
                repeat (gap_q[i]) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
            end
        end
        ififo_valid = 1'b0;
    endtask

    // transfers seen on the instruction input, taken at the following edge
    always @(negedge clk) begin : count_sent
        if (arst_n && ififo_valid && ififo_ready) begin
            sent++;
        end
    end

    // retire checker samples mid-cycle where outputs are settled
    always @(negedge clk) begin : check_retire
        retire_t want;
        string   test;
        if (!arst_n) begin
            check_value("reset", "retire_valid", 32'd0, 32'(retire_valid));
        end else if (retire_valid) begin
            if (expect_q.size() == 0) begin
                abort_run($sformatf("retire of pc %h with no instruction outstanding",
                                    retire_data.pc));
            end else begin
                want = expect_q.pop_front();
                test = name_q.pop_front();
                check_value(test, "pc", want.pc, retire_data.pc);
                check_value(test, "dst_valid", 32'(want.dst_valid), 32'(retire_data.dst_valid));
                check_value(test, "arf_id", 32'(want.arf_id), 32'(retire_data.arf_id));
                if (want.dst_valid) begin
                    check_value(test, "reg_data", want.reg_data, retire_data.reg_data);
                end
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout, retirement stalled with %0d of %0d retired",
                                retired, total));
        end
    end

    initial begin
        arst_n      = 1'b0;
        ififo_valid = 1'b0;
        ififo_data  = '0;
        rng_state   = SEED;
        for (int i = 0; i < N_ARF_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        total       = stim_q.size();
        cycle_limit = 8 * total + 200;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_value("reset", "ififo_ready", 32'd0, 32'(ififo_ready));
        arst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("reset", "ififo_ready", 32'd1, 32'(ififo_ready));
        @(posedge clk);
        #DRIVE_DELAY;

        send_all();
        while (retired < total) @(posedge clk);
        repeat (10) @(posedge clk);  // a stray extra retire would show up here
        check_value("end", "retire count", 32'(sent), 32'(retired));
        $display("Finished with no errors");
        $finish;
    end
endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/core_pkg.sv
verilog/decode.sv
verilog/regfile.sv
verilog/dispatch.sv
verilog/issue_queue.sv
verilog/alu_lane.sv
verilog/rob.sv
verilog/rename_core.sv
test/rename_core_assertions.sv
test/tb_rename_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_rename_core \
    --Mdir "$BUILD_DIR" -o Vtb_rename_core
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vtb_rename_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
